/* tests/core_vectors.txt */
# X pc word rd rd_we rd_data   program word and its expected retire, in retire order
# I addr word   never executed   D addr byte   initial data   S addr wdata wmask   store
X 00 00500093 01 1 00000005
X 04 FFD00113 02 1 FFFFFFFD
X 08 002081B3 03 1 00000002
X 0C 40208233 04 1 00000008
X 10 003092B3 05 1 00000014
X 14 00112333 06 1 00000001
X 18 001133B3 07 1 00000000
X 1C 0020C433 08 1 FFFFFFF8
X 20 001154B3 09 1 07FFFFFF
X 24 40115533 0A 1 FFFFFFFF
X 28 0030E5B3 0B 1 00000007
X 2C 0020F633 0C 1 00000005
X 30 0F017693 0D 1 000000F0
X 34 00409713 0E 1 00000050
X 38 40115793 0F 1 FFFFFFFE
X 3C FFE12813 10 1 00000001
X 40 FFF0C893 11 1 FFFFFFFA
X 44 12345937 12 1 12345000
X 48 00001997 13 1 00001048
X 4C 00708013 00 0 00000000
X 50 00000A33 14 1 00000000
X 54 00800AEF 15 1 00000058
I 58 00100F93
X 5C 07100B13 16 1 00000071
X 60 000B0BE7 17 1 00000064
I 64 00100F93
X 70 00108463 00 0 00000000
I 74 00100F93
X 78 00208463 00 0 00000000
X 7C 00209463 00 0 00000000
I 80 00100F93
X 84 00109463 00 0 00000000
X 88 00114463 00 0 00000000
I 8C 00100F93
X 90 0020C463 00 0 00000000
X 94 0020D463 00 0 00000000
I 98 00100F93
X 9C 00115463 00 0 00000000
X A0 0020E463 00 0 00000000
I A4 00100F93
X A8 00116463 00 0 00000000
X AC 00117463 00 0 00000000
I B0 00100F93
X B4 0020F463 00 0 00000000
X B8 10000C13 18 1 00000100
X BC 11223CB7 19 1 11223000
X C0 344C8C93 19 1 11223344
X C4 019C2023 00 0 00000000
X C8 002C1223 00 0 00000000
X CC 001C03A3 00 0 00000000
X D0 000C2D03 1A 1 11223344
X D4 004C0D83 1B 1 FFFFFFFD
X D8 004C4E03 1C 1 000000FD
X DC 004C1E83 1D 1 FFFFFFFD
X E0 006C5F03 1E 1 00000580
X E4 003C0F83 1F 1 00000011
X E8 008C1A03 14 1 FFFF9234
X EC 0000006F 00 0 00000000
D 106 80
D 108 34
D 109 92
S 100 11223344 F
S 104 FFFFFFFD 3
S 107 00000005 1

/* tb.f */
logic/core_pkg.sv
logic/inst_decoder.sv
logic/reg_file.sv
logic/exec_unit.sv
logic/load_store_unit.sv
logic/core_control.sv
logic/core_top.sv
tests/core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the core testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module core_tb -f tb.f -o core_sim \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/core_sim > sim.log 2>&1

grep -q "TEST PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

/* tests/core_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// core testbench with memory models, vector reader, retire and store checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module core_tb;

    localparam int max_recs = 128;

    logic                clk;
    logic                reset;
    core_pkg::word_t     imem_addr;
    logic                imem_re;
    core_pkg::word_t     imem_data;
    core_pkg::dmem_req_t dmem_req;
    core_pkg::word_t     dmem_rdata;
    core_pkg::retire_t   retire;

    logic [31:0] imem [256];   // 256 program words
    logic [7:0]  dmem [1024];  // 1 KiB of data bytes

    // expected retires in program order
    logic [31:0] exp_pc [max_recs];
    logic [31:0] exp_word [max_recs];
    logic [4:0]  exp_rd [max_recs];
    logic        exp_we [max_recs];
    logic [31:0] exp_data [max_recs];
    int          nret = 0;

    // expected stores
    logic [31:0] st_addr [max_recs];
    logic [31:0] st_wdata [max_recs];
    logic [3:0]  st_mask [max_recs];
    int          nstores = 0;

    int   errors = 0;
    int   r_idx = 0;
    int   s_idx = 0;
    int   cyc = 0;
    int   last_retire_cyc = 0;
    int   limit = 100;
    int   fetch_cnt = 0;  // request pulses since the last retire
    int   read_cnt = 0;
    int   write_cnt = 0;
    logic done = 1'b0;
    logic timed_out = 1'b0;
    logic seen_fetch = 1'b0;

    core_top #(
        .num_regs(32)
    ) core_top_i (
        .clk       (clk),
        .reset     (reset),
        .imem_addr (imem_addr),
        .imem_re   (imem_re),
        .imem_data (imem_data),
        .dmem_req  (dmem_req),
        .dmem_rdata(dmem_rdata),
        .retire    (retire)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // reads tagged lines and skips those opening with #
    task automatic load_vectors(output logic ok);
        int          fd;
        int          n;
        logic [63:0] tag;
        logic [31:0] a, b, c, d, e;
        logic [8*200-1:0] rest;
        ok = 1'b0;
        fd = $fopen("tests/core_vectors.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while (!$feof(fd)) begin
                tag = '0;
                n = $fscanf(fd, "%s", tag);
                if (n == 1) begin
                    if (tag == "#") begin
                        n = $fgets(rest, fd);
                    end else if (tag == "X") begin
                        n = $fscanf(fd, "%h %h %h %h %h", a, b, c, d, e);
                        imem[a[9:2]]    = b;
                        exp_pc[nret]    = a;
                        exp_word[nret]  = b;
                        exp_rd[nret]    = c[4:0];
                        exp_we[nret]    = d[0];
                        exp_data[nret]  = e;
                        nret++;
                    end else if (tag == "I") begin
                        n = $fscanf(fd, "%h %h", a, b);
                        imem[a[9:2]] = b;
                    end else if (tag == "D") begin
                        n = $fscanf(fd, "%h %h", a, b);
                        dmem[a[9:0]] = b[7:0];
                    end else if (tag == "S") begin
                        n = $fscanf(fd, "%h %h %h", a, b, c);
                        st_addr[nstores]  = a;
                        st_wdata[nstores] = b;
                        st_mask[nstores]  = c[3:0];
                        nstores++;
                    end else begin
                        $display("unknown line tag in the vector file");
                        errors++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // one-cycle synchronous memories
    always @(posedge clk) begin
        if (imem_re) begin
            imem_data <= imem[imem_addr[9:2]];
        end
        if (dmem_req.re) begin
            dmem_rdata <= {dmem[dmem_req.addr[9:0] + 10'd3], dmem[dmem_req.addr[9:0] + 10'd2],
                           dmem[dmem_req.addr[9:0] + 10'd1], dmem[dmem_req.addr[9:0]]};
        end
        if (dmem_req.we) begin
            for (int b = 0; b < 4; b++) begin
                if (dmem_req.wmask[b]) begin
                    dmem[dmem_req.addr[9:0] + 10'(b)] <= dmem_req.wdata[8*b +: 8];
                end
            end
        end
    end

    always @(posedge clk) begin
        if (!reset) begin
            cyc <= cyc + 1;
            if (cyc >= limit) begin
                timed_out <= 1'b1;
            end
        end
    end

    // sampled mid-cycle where the outputs are settled
    always @(negedge clk) begin
        logic is_ld;
        logic is_st;
        if (!reset) begin
            if (imem_re && !seen_fetch) begin
                check("first fetch address", imem_addr, 32'h0000_0000);
                seen_fetch = 1'b1;
            end
            if (imem_re) begin
                fetch_cnt++;
            end
            if (dmem_req.re) begin
                read_cnt++;
            end
            if (dmem_req.we) begin
                write_cnt++;
            end
            if (retire.valid && r_idx < nret) begin
                check("retire pc", retire.pc, exp_pc[r_idx]);
                check("retire rd_we", {31'b0, retire.rd_we}, {31'b0, exp_we[r_idx]});
                if (exp_we[r_idx]) begin
                    check("retire rd", {27'b0, retire.rd}, {27'b0, exp_rd[r_idx]});
                    check("retire rd_data", retire.rd_data, exp_data[r_idx]);
                end
                is_ld = (exp_word[r_idx][6:0] == 7'h03);
                is_st = (exp_word[r_idx][6:0] == 7'h23);
                check("fetches per instruction", fetch_cnt, 1);
                check("data reads per instruction", read_cnt, {31'b0, is_ld});
                check("data writes per instruction", write_cnt, {31'b0, is_st});
                fetch_cnt = 0;
                read_cnt  = 0;
                write_cnt = 0;
                if (r_idx > 0) begin
                    check("retire spacing", cyc - last_retire_cyc, (is_ld || is_st) ? 5 : 4);
                end
                last_retire_cyc = cyc;
                r_idx++;
                if (r_idx == nret) begin
                    done = 1'b1;
                end
            end
            if (dmem_req.we && !done) begin
                if (s_idx < nstores) begin
                    check("store addr", dmem_req.addr, st_addr[s_idx]);
                    check("store wdata", dmem_req.wdata, st_wdata[s_idx]);
                    check("store wmask", {28'b0, dmem_req.wmask}, {28'b0, st_mask[s_idx]});
                end else begin
                    $display("the core wrote more stores than expected at %0t", $time);
                    errors++;
                end
                s_idx++;
            end
        end
    end

    initial begin
        logic ok;
        reset      = 1'b1;
        imem_data  = '0;
        dmem_rdata = '0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
        end
        for (int i = 0; i < 1024; i++) begin
            dmem[i] = 8'(i * 13 + (i >> 8) + 8'h5a);
        end
        load_vectors(ok);
        limit = 5 * nret + 100;
        if (ok) begin
            repeat (10) @(posedge clk);
            reset <= 1'b0;
            wait (done || timed_out);
            repeat (2) @(posedge clk);
        end else begin
            $display("could not open tests/core_vectors.txt");
            errors++;
        end
        if (timed_out) begin
            $display("timeout, the core stopped retiring after %0d of %0d instructions",
                     r_idx, nret);
        end
        check("store count", s_idx, nstores);
        $display("errors %0d, retires %0d of %0d, stores %0d of %0d",
                 errors, r_idx, nret, s_idx, nstores);
        if (errors == 0 && !timed_out) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* logic/core_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// core top level, wires control, decode, registers, execute and LSU
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module core_top #(
    parameter int num_regs = 32
) (
    input  logic               clk,
    input  logic               reset,
    output core_pkg::word_t    imem_addr,
    output logic               imem_re,
    input  core_pkg::word_t    imem_data,
    output core_pkg::dmem_req_t dmem_req,
    input  core_pkg::word_t    dmem_rdata,
    output core_pkg::retire_t  retire
);

    core_pkg::word_t   pc;
    core_pkg::word_t   inst;
    core_pkg::decode_t dec;
    core_pkg::word_t   rs1_data, rs2_data;
    core_pkg::word_t   alu_result, ex_result;
    logic              jump_en;
    core_pkg::word_t   jump_target;
    core_pkg::word_t   load_data;
    logic              mem_phase;
    logic              rd_we;
    core_pkg::word_t   rd_wdata;

    core_control core_control_i (
        .clk        (clk),
        .reset      (reset),
        .imem_data  (imem_data),
        .dec        (dec),
        .jump_en    (jump_en),
        .jump_target(jump_target),
        .ex_result  (ex_result),
        .load_data  (load_data),
        .imem_addr  (imem_addr),
        .imem_re    (imem_re),
        .pc         (pc),
        .inst       (inst),
        .mem_phase  (mem_phase),
        .rd_we      (rd_we),
        .rd_wdata   (rd_wdata),
        .retire     (retire)
    );

    inst_decoder inst_decoder_i (
        .inst(inst),
        .dec (dec)
    );

    reg_file #(
        .num_regs(num_regs)
    ) reg_file_i (
        .clk     (clk),
        .reset   (reset),
        .rs1     (dec.rs1),
        .rs2     (dec.rs2),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .we      (rd_we),
        .rd      (dec.rd),     // held in the instruction register through writeback
        .wdata   (rd_wdata)
    );

    exec_unit exec_unit_i (
        .dec        (dec),
        .pc         (pc),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .alu_result (alu_result),
        .ex_result  (ex_result),
        .jump_en    (jump_en),
        .jump_target(jump_target)
    );

    load_store_unit load_store_unit_i (
        .clk       (clk),
        .reset     (reset),
        .dec       (dec),
        .mem_phase (mem_phase),
        .addr      (alu_result),  // rs1 + imm
        .store_data(rs2_data),
        .dmem_rdata(dmem_rdata),
        .dmem_req  (dmem_req),
        .load_data (load_data)
    );

endmodule

`default_nettype wire

/* logic/core_control.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// control FSM with pc, instruction register, writeback and retire
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module core_control (
    input  logic              clk,
    input  logic              reset,
    input  core_pkg::word_t   imem_data,
    input  core_pkg::decode_t dec,
    input  logic              jump_en,
    input  core_pkg::word_t   jump_target,
    input  core_pkg::word_t   ex_result,
    input  core_pkg::word_t   load_data,
    output core_pkg::word_t   imem_addr,
    output logic              imem_re,
    output core_pkg::word_t   pc,
    output core_pkg::word_t   inst,
    output logic              mem_phase,
    output logic              rd_we,
    output core_pkg::word_t   rd_wdata,
    output core_pkg::retire_t retire
);

    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_execute,
        st_mem,
        st_writeback
    } state_t;

    state_t          state, next_state;
    core_pkg::word_t next_pc;

    always_comb begin
        next_state = state;
        case (state)
            st_fetch:     next_state = st_decode;
            st_decode:    next_state = st_execute;
            st_execute:   next_state = (dec.is_load || dec.is_store) ? st_mem : st_writeback;
            st_mem:       next_state = st_writeback;
            st_writeback: next_state = st_fetch;
            default:      next_state = st_fetch;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_fetch;
        end else begin
            state <= next_state;
        end
    end

    assign next_pc = jump_en ? jump_target : pc + 32'd4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= core_pkg::reset_pc;
        end else if (state == st_writeback) begin
            pc <= next_pc;
        end
    end

    // fetched word arrives the cycle after imem_re
    always_ff @(posedge clk) begin
        if (state == st_decode) begin
            inst <= imem_data;
        end
    end

    assign imem_addr = pc;
    assign imem_re   = (state == st_fetch);
    assign mem_phase = (state == st_mem);

    // x0 writes are dropped here so retire reports them too
    assign rd_we    = (state == st_writeback) && dec.writes_rd && (dec.rd != 5'd0);
    assign rd_wdata = dec.is_load ? load_data : ex_result;

    always_comb begin
        retire.valid   = (state == st_writeback);
        retire.pc      = pc;
        retire.rd      = dec.rd;
        retire.rd_we   = rd_we;
        retire.rd_data = rd_wdata;
    end

endmodule

`default_nettype wire

/* logic/load_store_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data port requests and load data extension
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module load_store_unit (
    input  logic                clk,
    input  logic                reset,
    input  core_pkg::decode_t   dec,
    input  logic                mem_phase,
    input  core_pkg::word_t     addr,
    input  core_pkg::word_t     store_data,
    input  core_pkg::word_t     dmem_rdata,
    output core_pkg::dmem_req_t dmem_req,
    output core_pkg::word_t     load_data
);

    logic       load_pending;  // data on dmem_rdata this cycle
    logic [2:0] load_size;

    always_comb begin
        dmem_req.addr  = addr;
        dmem_req.wdata = store_data;  // unshifted, byte 0 first
        case (dec.funct3[1:0])
            2'b00:   dmem_req.wmask = 4'h1;
            2'b01:   dmem_req.wmask = 4'h3;
            default: dmem_req.wmask = 4'hF;
        endcase
        dmem_req.re = mem_phase && dec.is_load;
        dmem_req.we = mem_phase && dec.is_store;
    end

    // the answer comes one cycle after the request
    always_ff @(posedge clk) begin
        if (reset) begin
            load_pending <= 1'b0;
        end else begin
            load_pending <= dmem_req.re;
        end
    end

    always_ff @(posedge clk) begin
        if (dmem_req.re) begin
            load_size <= dec.funct3;
        end
    end

    always_comb begin
        load_data = '0;
        if (load_pending) begin
            case (load_size)
                3'b000:  load_data = {{24{dmem_rdata[7]}}, dmem_rdata[7:0]};    // lb
                3'b001:  load_data = {{16{dmem_rdata[15]}}, dmem_rdata[15:0]};  // lh
                3'b100:  load_data = {24'b0, dmem_rdata[7:0]};                  // lbu
                3'b101:  load_data = {16'b0, dmem_rdata[15:0]};                 // lhu
                default: load_data = dmem_rdata;                                // lw
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/exec_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// operand select, ALU, branch compare, jump target and link value
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module exec_unit (
    input  core_pkg::decode_t dec,
    input  core_pkg::word_t   pc,
    input  core_pkg::word_t   rs1_data,
    input  core_pkg::word_t   rs2_data,
    output core_pkg::word_t   alu_result,
    output core_pkg::word_t   ex_result,
    output logic              jump_en,
    output core_pkg::word_t   jump_target
);

    core_pkg::word_t alu_a, alu_b;
    logic [4:0]      shamt;
    logic            is_jal, is_jalr;
    logic            take_branch;

    assign is_jal  = (dec.opcode == core_pkg::op_jal);
    assign is_jalr = (dec.opcode == core_pkg::op_jalr);

    always_comb begin
        if (dec.opcode == core_pkg::op_auipc || is_jal || dec.kind == core_pkg::kind_b) begin
            alu_a = pc;
        end else if (dec.opcode == core_pkg::op_lui) begin
            alu_a = '0;
        end else begin
            alu_a = rs1_data;
        end
        alu_b = (dec.kind == core_pkg::kind_r) ? rs2_data : dec.imm;
    end

    assign shamt = alu_b[4:0];

    always_comb begin
        case (dec.alu_op)
            core_pkg::alu_sub:  alu_result = alu_a - alu_b;
            core_pkg::alu_sll:  alu_result = alu_a << shamt;
            core_pkg::alu_slt:  alu_result = {31'b0, $signed(alu_a) < $signed(alu_b)};
            core_pkg::alu_sltu: alu_result = {31'b0, alu_a < alu_b};
            core_pkg::alu_xor:  alu_result = alu_a ^ alu_b;
            core_pkg::alu_srl:  alu_result = alu_a >> shamt;
            core_pkg::alu_sra:  alu_result = $unsigned($signed(alu_a) >>> shamt);
            core_pkg::alu_or:   alu_result = alu_a | alu_b;
            core_pkg::alu_and:  alu_result = alu_a & alu_b;
            default:            alu_result = alu_a + alu_b;
        endcase
    end

    // compare always on the register values
    always_comb begin
        case (dec.funct3)
            3'b000:  take_branch = (rs1_data == rs2_data);                   // beq
            3'b001:  take_branch = (rs1_data != rs2_data);                   // bne
            3'b100:  take_branch = ($signed(rs1_data) < $signed(rs2_data));  // blt
            3'b101:  take_branch = ($signed(rs1_data) >= $signed(rs2_data)); // bge
            3'b110:  take_branch = (rs1_data < rs2_data);                    // bltu
            3'b111:  take_branch = (rs1_data >= rs2_data);                   // bgeu
            default: take_branch = 1'b0;
        endcase
    end

    assign jump_en     = is_jal || is_jalr || (dec.kind == core_pkg::kind_b && take_branch);
    assign jump_target = is_jalr ? {alu_result[31:1], 1'b0} : alu_result;
    assign ex_result   = (is_jal || is_jalr) ? pc + 32'd4 : alu_result;  // link value

endmodule

`default_nettype wire

/* logic/reg_file.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// general registers, two read ports and one write port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module reg_file #(
    parameter int num_regs = 32
) (
    input  logic                clk,
    input  logic                reset,
    input  core_pkg::reg_addr_t rs1,
    input  core_pkg::reg_addr_t rs2,
    output core_pkg::word_t     rs1_data,
    output core_pkg::word_t     rs2_data,
    input  logic                we,
    input  core_pkg::reg_addr_t rd,
    input  core_pkg::word_t     wdata
);

    localparam int idx_w = $clog2(num_regs);

    core_pkg::word_t regs [num_regs];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0 && rd < num_regs) begin
            regs[rd[idx_w-1:0]] <= wdata;
        end
    end

    // x0 and indices past the array read as zero
    assign rs1_data = (rs1 == 5'd0 || rs1 >= num_regs) ? '0 : regs[rs1[idx_w-1:0]];
    assign rs2_data = (rs2 == 5'd0 || rs2 >= num_regs) ? '0 : regs[rs2[idx_w-1:0]];

endmodule

`default_nettype wire

/* logic/inst_decoder.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I decoder, fields, format, immediate and ALU operation
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module inst_decoder (
    input  core_pkg::word_t   inst,
    output core_pkg::decode_t dec
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;      // funct7[5] selects sub and sra

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign alt    = inst[30];

    always_comb begin
        dec.opcode = opcode;
        dec.funct3 = funct3;
        dec.rd     = inst[11:7];
        dec.rs1    = inst[19:15];
        dec.rs2    = inst[24:20];

        case (opcode)
            core_pkg::op_alu_reg:                     dec.kind = core_pkg::kind_r;
            core_pkg::op_alu_imm, core_pkg::op_load,
            core_pkg::op_jalr:                        dec.kind = core_pkg::kind_i;
            core_pkg::op_store:                       dec.kind = core_pkg::kind_s;
            core_pkg::op_branch:                      dec.kind = core_pkg::kind_b;
            core_pkg::op_lui, core_pkg::op_auipc:     dec.kind = core_pkg::kind_u;
            core_pkg::op_jal:                         dec.kind = core_pkg::kind_j;
            default:                                  dec.kind = core_pkg::kind_n;
        endcase

        case (dec.kind)
            core_pkg::kind_i: dec.imm = {{20{inst[31]}}, inst[31:20]};
            core_pkg::kind_s: dec.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            core_pkg::kind_b: dec.imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            core_pkg::kind_u: dec.imm = {inst[31:12], 12'b0};
            core_pkg::kind_j: dec.imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default:          dec.imm = '0;
        endcase

        dec.alu_op = core_pkg::alu_add;  // address and link arithmetic
        if (opcode == core_pkg::op_alu_imm || opcode == core_pkg::op_alu_reg) begin
            case (funct3)
                3'b000: dec.alu_op = (opcode == core_pkg::op_alu_reg && alt) ?
                                     core_pkg::alu_sub : core_pkg::alu_add;
                3'b001: dec.alu_op = core_pkg::alu_sll;
                3'b010: dec.alu_op = core_pkg::alu_slt;
                3'b011: dec.alu_op = core_pkg::alu_sltu;
                3'b100: dec.alu_op = core_pkg::alu_xor;
                3'b101: dec.alu_op = alt ? core_pkg::alu_sra : core_pkg::alu_srl;
                3'b110: dec.alu_op = core_pkg::alu_or;
                default: dec.alu_op = core_pkg::alu_and;
            endcase
        end

        dec.is_load   = (opcode == core_pkg::op_load);
        dec.is_store  = (opcode == core_pkg::op_store);
        dec.writes_rd = (dec.kind == core_pkg::kind_r) || (dec.kind == core_pkg::kind_u)
                     || (dec.kind == core_pkg::kind_j) || (opcode == core_pkg::op_jalr)
                     || (opcode == core_pkg::op_load) || (opcode == core_pkg::op_alu_imm);
    end

endmodule

`default_nettype wire

/* logic/core_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared widths, opcodes, enums and bus structs of the RV32I core
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package core_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    localparam word_t reset_pc = 32'h0000_0000;  // first fetch address

    // major opcodes, inst[6:0]
    localparam logic [6:0] op_lui     = 7'b0110111;
    localparam logic [6:0] op_auipc   = 7'b0010111;
    localparam logic [6:0] op_jal     = 7'b1101111;
    localparam logic [6:0] op_jalr    = 7'b1100111;
    localparam logic [6:0] op_branch  = 7'b1100011;
    localparam logic [6:0] op_load    = 7'b0000011;
    localparam logic [6:0] op_store   = 7'b0100011;
    localparam logic [6:0] op_alu_imm = 7'b0010011;
    localparam logic [6:0] op_alu_reg = 7'b0110011;

    // instruction format
    typedef enum logic [2:0] {
        kind_r,
        kind_i,
        kind_s,
        kind_b,
        kind_u,
        kind_j,
        kind_n  // unknown opcode
    } inst_kind_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    typedef struct packed {
        logic [6:0] opcode;
        logic [2:0] funct3;
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        word_t      imm;        // sign-extended for its format
        inst_kind_t kind;
        alu_op_t    alu_op;
        logic       is_load;
        logic       is_store;
        logic       writes_rd;
    } decode_t;

    // data port request, wdata unshifted and mask low-aligned
    typedef struct packed {
        word_t      addr;
        word_t      wdata;
        logic [3:0] wmask;
        logic       re;
        logic       we;
    } dmem_req_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rd;
        logic      rd_we;
        word_t     rd_data;
    } retire_t;

endpackage

`default_nettype wire
